// ==== hdl/afu_pkg.sv ====
// ==============================
// Shared widths, types, host address offsets and handshake line layout
// for the batch engine. Referenced by scoped name only.
// ==============================
package afu_pkg;

	// ==============================
	// Data and address types
	// ==============================
	typedef logic [511:0] cl_t;
	typedef logic [57:0]  addr_t;
	typedef logic [63:0]  host_ptr_t;

	// One bit wider than the read index, so a full batch of 256 fits
	typedef logic [8:0]   batch_size_t;
	typedef logic [10:0]  cl_count_t;

	localparam int CL_PER_READ = 4;

	// Line offsets from the source pointer
	localparam host_ptr_t HANDSHAKE_OFFSET = host_ptr_t'(50331648 + 16384 - 1);
	localparam host_ptr_t INPUT_OFFSET     = HANDSHAKE_OFFSET + host_ptr_t'(1);

	// ==============================
	// Handshake line fields
	// ==============================
	localparam int TAG0_BIT  = 480;
	localparam int TAG1_BIT  = 482;
	localparam int BATCH_LSB = 448;

	// Top 32 bits of the done word
	localparam logic [31:0] DONE_CODE = 32'd16;

	// ==============================
	// FSM encodings
	// ==============================
	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_POLL,
		FETCH_CHECK,
		FETCH_LOAD,
		FETCH_WAIT_DONE
	} fetch_state_t;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_READ,
		WR_SEND,
		WR_FENCE,
		WR_DONE,
		WR_FENCE_2
	} writer_state_t;

endpackage

// ==== hdl/batch_fetch.sv ====
// ==============================
// Polls the host handshake line, then streams the batch's input lines
// into the read buffer. Hands the batch to the writer via batch_ready.
// ==============================
`timescale 1ns/1ns

module batch_fetch #(
	parameter int MAX_READS = 256
) (
	input  logic                CLK_400M,
	input  logic                reset_n,
	input  logic                core_start,
	input  afu_pkg::host_ptr_t  io_src_ptr,
	input  logic                spl_tx_rd_almostfull,
	input  logic                io_rx_rd_valid,
	input  afu_pkg::cl_t        io_rx_data,
	input  logic                batch_done,
	output logic                cor_tx_rd_valid,
	output afu_pkg::addr_t      cor_tx_rd_addr,
	output logic                buf_wr_en,
	output afu_pkg::cl_count_t  buf_wr_addr,
	output afu_pkg::cl_t        buf_wr_data,
	output logic                batch_ready,
	output afu_pkg::cl_count_t  batch_lines
);

	// Largest batch the buffer can hold
	localparam afu_pkg::batch_size_t MAX_SIZE = afu_pkg::batch_size_t'(MAX_READS);

	afu_pkg::fetch_state_t state;
	logic                  expected_tag;
	logic                  rd_req_q;
	afu_pkg::addr_t        rd_addr_q;
	afu_pkg::cl_count_t    issue_cnt;
	afu_pkg::cl_count_t    recv_cnt;

	afu_pkg::addr_t        hand_base;
	afu_pkg::addr_t        input_base;
	logic                  rd_fire;
	logic                  tag_hit;
	afu_pkg::batch_size_t  hs_batch_size;
	afu_pkg::batch_size_t  load_reads;

	assign hand_base  = afu_pkg::addr_t'(io_src_ptr + afu_pkg::HANDSHAKE_OFFSET);
	assign input_base = afu_pkg::addr_t'(io_src_ptr + afu_pkg::INPUT_OFFSET);

	// ==============================
	// Handshake line decode
	// ==============================
	assign tag_hit = expected_tag ? io_rx_data[afu_pkg::TAG1_BIT]
	                              : io_rx_data[afu_pkg::TAG0_BIT];
	assign hs_batch_size = io_rx_data[afu_pkg::BATCH_LSB +: $bits(afu_pkg::batch_size_t)];
	assign load_reads = (hs_batch_size > MAX_SIZE) ? MAX_SIZE : hs_batch_size;

	// Pending request goes out only while the read path has room
	assign rd_fire         = rd_req_q & ~spl_tx_rd_almostfull;
	assign cor_tx_rd_valid = rd_fire;
	assign cor_tx_rd_addr  = rd_addr_q;

	// Responses land in the buffer the cycle they arrive
	assign buf_wr_en   = (state == afu_pkg::FETCH_LOAD) & io_rx_rd_valid;
	assign buf_wr_addr = recv_cnt;
	assign buf_wr_data = io_rx_data;

	// ==============================
	// Fetch FSM
	// ==============================
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			state        <= afu_pkg::FETCH_IDLE;
			expected_tag <= 1'b0;
			rd_req_q     <= 1'b0;
			issue_cnt    <= '0;
			recv_cnt     <= '0;
			batch_lines  <= '0;
			batch_ready  <= 1'b0;
		end else begin
			batch_ready <= 1'b0;
			case (state)
				afu_pkg::FETCH_IDLE: begin
					rd_req_q <= 1'b0;
					if (core_start) begin
						state <= afu_pkg::FETCH_POLL;
					end
				end

				afu_pkg::FETCH_POLL: begin
					rd_req_q  <= 1'b1;
					rd_addr_q <= hand_base;
					state     <= afu_pkg::FETCH_CHECK;
				end

				// One handshake read in flight, wait for its line
				afu_pkg::FETCH_CHECK: begin
					if (rd_fire) begin
						rd_req_q <= 1'b0;
					end
					if (io_rx_rd_valid) begin
						if (tag_hit) begin
							expected_tag <= ~expected_tag;
							batch_lines  <= afu_pkg::cl_count_t'(load_reads * afu_pkg::CL_PER_READ);
							issue_cnt    <= '0;
							recv_cnt     <= '0;
							state        <= afu_pkg::FETCH_LOAD;
						end else begin
							state <= afu_pkg::FETCH_POLL;
						end
					end
				end

				afu_pkg::FETCH_LOAD: begin
					// Refill the request slot whenever it is free or just went out
					if (!rd_req_q || rd_fire) begin
						if (issue_cnt != batch_lines) begin
							rd_req_q  <= 1'b1;
							rd_addr_q <= input_base + afu_pkg::addr_t'(issue_cnt);
							issue_cnt <= issue_cnt + 1'b1;
						end else begin
							rd_req_q <= 1'b0;
						end
					end
					if (io_rx_rd_valid) begin
						recv_cnt <= recv_cnt + 1'b1;
					end
					if (issue_cnt == batch_lines && recv_cnt == batch_lines) begin
						batch_ready <= 1'b1;
						state       <= afu_pkg::FETCH_WAIT_DONE;
					end
				end

				afu_pkg::FETCH_WAIT_DONE: begin
					if (batch_done) begin
						state <= afu_pkg::FETCH_IDLE;
					end
				end

				default: begin
					state <= afu_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hdl/read_buffer.sv ====
// ==============================
// Line memory for one batch. One write port from the fetch stage,
// one registered read port for the writer.
// ==============================
`timescale 1ns/1ns

module read_buffer #(
	parameter int MAX_READS = 256
) (
	input  logic                CLK_400M,
	input  logic                buf_wr_en,
	input  afu_pkg::cl_count_t  buf_wr_addr,
	input  afu_pkg::cl_t        buf_wr_data,
	input  afu_pkg::cl_count_t  buf_rd_addr,
	output afu_pkg::cl_t        buf_rd_data
);

	// Four lines per read
	localparam int DEPTH = MAX_READS * afu_pkg::CL_PER_READ;
	localparam int AW    = $clog2(DEPTH);

	afu_pkg::cl_t mem [DEPTH];

	always_ff @(posedge CLK_400M) begin
		if (buf_wr_en) begin
			mem[buf_wr_addr[AW-1:0]] <= buf_wr_data;
		end
	end

	// Read data follows the address by one cycle
	always_ff @(posedge CLK_400M) begin
		buf_rd_data <= mem[buf_rd_addr[AW-1:0]];
	end

endmodule

// ==== hdl/result_writer.sv ====
// ==============================
// Copies buffered lines to the destination area, then closes the batch
// with fence, done word to the handshake line, and a second fence.
// ==============================
`timescale 1ns/1ns

module result_writer (
	input  logic                CLK_400M,
	input  logic                reset_n,
	input  afu_pkg::host_ptr_t  io_src_ptr,
	input  afu_pkg::host_ptr_t  io_dst_ptr,
	input  logic                spl_tx_wr_almostfull,
	input  logic                batch_ready,
	input  afu_pkg::cl_count_t  batch_lines,
	input  afu_pkg::cl_t        buf_rd_data,
	output afu_pkg::cl_count_t  buf_rd_addr,
	output logic                cor_tx_wr_valid,
	output logic                cor_tx_fence_valid,
	output logic                cor_tx_done_valid,
	output afu_pkg::addr_t      cor_tx_wr_addr,
	output afu_pkg::cl_t        cor_tx_data,
	output logic                batch_done
);

	// Done code in the top word, zero below
	localparam afu_pkg::cl_t DONE_WORD =
		{afu_pkg::DONE_CODE, {($bits(afu_pkg::cl_t) - 32){1'b0}}};

	afu_pkg::writer_state_t state;
	afu_pkg::cl_count_t     line_idx;
	afu_pkg::cl_count_t     line_count;

	afu_pkg::addr_t         hand_base;
	afu_pkg::addr_t         dst_base;
	logic                   wr_go;
	logic                   wr_req;
	logic                   is_fence;
	logic                   last_line;

	assign hand_base = afu_pkg::addr_t'(io_src_ptr + afu_pkg::HANDSHAKE_OFFSET);
	assign dst_base  = afu_pkg::addr_t'(io_dst_ptr);

	assign wr_go     = ~spl_tx_wr_almostfull;
	assign last_line = (line_idx == line_count - 1'b1);

	// ==============================
	// Write request outputs
	// ==============================
	// States that hold a write waiting for room
	assign wr_req = (state == afu_pkg::WR_SEND) || (state == afu_pkg::WR_FENCE) ||
	                (state == afu_pkg::WR_DONE) || (state == afu_pkg::WR_FENCE_2);
	assign is_fence = (state == afu_pkg::WR_FENCE) || (state == afu_pkg::WR_FENCE_2);

	assign cor_tx_wr_valid    = wr_req & wr_go;
	assign cor_tx_fence_valid = is_fence & wr_go;
	assign cor_tx_done_valid  = (state == afu_pkg::WR_DONE) & wr_go;

	assign buf_rd_addr = line_idx;

	always_comb begin
		case (state)
			afu_pkg::WR_SEND: begin
				cor_tx_wr_addr = dst_base + afu_pkg::addr_t'(line_idx);
				cor_tx_data    = buf_rd_data;
			end
			afu_pkg::WR_DONE: begin
				cor_tx_wr_addr = hand_base;
				cor_tx_data    = DONE_WORD;
			end
			default: begin
				cor_tx_wr_addr = hand_base;
				cor_tx_data    = '0;
			end
		endcase
	end

	// ==============================
	// Writer FSM
	// ==============================
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			state      <= afu_pkg::WR_IDLE;
			line_idx   <= '0;
			line_count <= '0;
			batch_done <= 1'b0;
		end else begin
			batch_done <= 1'b0;
			case (state)
				afu_pkg::WR_IDLE: begin
					if (batch_ready) begin
						line_idx   <= '0;
						line_count <= batch_lines;
						// Empty batch only gets the closing sequence
						state <= (batch_lines == '0) ? afu_pkg::WR_FENCE : afu_pkg::WR_READ;
					end
				end

				// Address is on the buffer, data valid next cycle
				afu_pkg::WR_READ: begin
					state <= afu_pkg::WR_SEND;
				end

				afu_pkg::WR_SEND: begin
					if (wr_go) begin
						line_idx <= line_idx + 1'b1;
						state    <= last_line ? afu_pkg::WR_FENCE : afu_pkg::WR_READ;
					end
				end

				afu_pkg::WR_FENCE: begin
					if (wr_go) begin
						state <= afu_pkg::WR_DONE;
					end
				end

				afu_pkg::WR_DONE: begin
					if (wr_go) begin
						state <= afu_pkg::WR_FENCE_2;
					end
				end

				afu_pkg::WR_FENCE_2: begin
					if (wr_go) begin
						batch_done <= 1'b1;
						state      <= afu_pkg::WR_IDLE;
					end
				end

				default: begin
					state <= afu_pkg::WR_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hdl/afu_core.sv ====
// ==============================
// Batch engine top. Connects fetch, buffer and write-back stages
// to the host read and write ports.
// ==============================
`timescale 1ns/1ns

module afu_core #(
	parameter int MAX_READS = 256
) (
	input  logic                CLK_400M,
	input  logic                reset_n,
	input  logic                core_start,

	// Host read request and response
	input  logic                spl_tx_rd_almostfull,
	output logic                cor_tx_rd_valid,
	output afu_pkg::addr_t      cor_tx_rd_addr,
	input  logic                io_rx_rd_valid,
	input  afu_pkg::cl_t        io_rx_data,

	// Host write request
	input  logic                spl_tx_wr_almostfull,
	output logic                cor_tx_wr_valid,
	output logic                cor_tx_fence_valid,
	output logic                cor_tx_done_valid,
	output afu_pkg::addr_t      cor_tx_wr_addr,
	output afu_pkg::cl_t        cor_tx_data,

	// Line pointers from the host
	input  afu_pkg::host_ptr_t  io_src_ptr,
	input  afu_pkg::host_ptr_t  io_dst_ptr
);

	// ==============================
	// Stage interconnect
	// ==============================
	logic               buf_wr_en;
	afu_pkg::cl_count_t buf_wr_addr;
	afu_pkg::cl_t       buf_wr_data;
	afu_pkg::cl_count_t buf_rd_addr;
	afu_pkg::cl_t       buf_rd_data;
	logic               batch_ready;
	afu_pkg::cl_count_t batch_lines;
	logic               batch_done;

	batch_fetch #(
		.MAX_READS(MAX_READS)
	) fetch_i (
		.CLK_400M(CLK_400M),
		.reset_n(reset_n),
		.core_start(core_start),
		.io_src_ptr(io_src_ptr),
		.spl_tx_rd_almostfull(spl_tx_rd_almostfull),
		.io_rx_rd_valid(io_rx_rd_valid),
		.io_rx_data(io_rx_data),
		.batch_done(batch_done),
		.cor_tx_rd_valid(cor_tx_rd_valid),
		.cor_tx_rd_addr(cor_tx_rd_addr),
		.buf_wr_en(buf_wr_en),
		.buf_wr_addr(buf_wr_addr),
		.buf_wr_data(buf_wr_data),
		.batch_ready(batch_ready),
		.batch_lines(batch_lines)
	);

	read_buffer #(
		.MAX_READS(MAX_READS)
	) buffer_i (
		.CLK_400M(CLK_400M),
		.buf_wr_en(buf_wr_en),
		.buf_wr_addr(buf_wr_addr),
		.buf_wr_data(buf_wr_data),
		.buf_rd_addr(buf_rd_addr),
		.buf_rd_data(buf_rd_data)
	);

	result_writer writer_i (
		.CLK_400M(CLK_400M),
		.reset_n(reset_n),
		.io_src_ptr(io_src_ptr),
		.io_dst_ptr(io_dst_ptr),
		.spl_tx_wr_almostfull(spl_tx_wr_almostfull),
		.batch_ready(batch_ready),
		.batch_lines(batch_lines),
		.buf_rd_data(buf_rd_data),
		.buf_rd_addr(buf_rd_addr),
		.cor_tx_wr_valid(cor_tx_wr_valid),
		.cor_tx_fence_valid(cor_tx_fence_valid),
		.cor_tx_done_valid(cor_tx_done_valid),
		.cor_tx_wr_addr(cor_tx_wr_addr),
		.cor_tx_data(cor_tx_data),
		.batch_done(batch_done)
	);

endmodule

// ==== tb/clk_gen.sv ====
// ==============================
// Testbench clock and reset source, 10 ns period
// ==============================
`timescale 1ns/1ns

module clk_gen #(
	parameter int RESET_CYCLES = 16
) (
	output logic CLK_400M,
	output logic reset_n
);

	initial begin
		CLK_400M = 1'b0;
		forever #5 CLK_400M = ~CLK_400M;
	end

	// Release on a falling edge like every other input
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_400M);
		@(negedge CLK_400M);
		reset_n = 1'b1;
	end

endmodule

// ==== tb/afu_core_tb.sv ====
// ==============================
// Batch engine testbench. Host memory model, batch stimulus and
// a checker on every host read and write.
// ==============================
`timescale 1ns/1ns

module afu_core_tb;

	localparam int MAX_READS = 256;
	localparam int WAIT_LIMIT = 5000;
	localparam afu_pkg::host_ptr_t SRC_PTR = 64'h0000_0000_0010_0000;
	localparam afu_pkg::host_ptr_t DST_PTR = 64'h0000_0000_0400_0000;
	// Handshake line sits just below the input area
	localparam afu_pkg::host_ptr_t HS_OFS = 64'd50331648 + 64'd16384 - 64'd1;

	logic               CLK_400M;
	logic               reset_n;
	logic               core_start;
	logic               spl_tx_rd_almostfull;
	logic               spl_tx_wr_almostfull;
	logic               io_rx_rd_valid;
	afu_pkg::cl_t       io_rx_data;
	afu_pkg::host_ptr_t io_src_ptr;
	afu_pkg::host_ptr_t io_dst_ptr;
	logic               cor_tx_rd_valid;
	afu_pkg::addr_t     cor_tx_rd_addr;
	logic               cor_tx_wr_valid;
	logic               cor_tx_fence_valid;
	logic               cor_tx_done_valid;
	afu_pkg::addr_t     cor_tx_wr_addr;
	afu_pkg::cl_t       cor_tx_data;

	// Host memory and batch bookkeeping
	afu_pkg::cl_t       hs_line;
	logic [31:0]        salt;
	afu_pkg::cl_count_t cur_lines;
	afu_pkg::cl_count_t load_cnt;
	int                 wr_step;
	int                 poll_cnt;
	int                 batches_done;
	logic               armed;
	logic               started;
	int                 cycle;
	int                 last_due;
	afu_pkg::addr_t     new_reqs[$];
	afu_pkg::addr_t     pend_addr[$];
	int                 pend_due[$];

	clk_gen #(.RESET_CYCLES(16)) clk_i (
		.CLK_400M(CLK_400M),
		.reset_n(reset_n)
	);

	afu_core #(
		.MAX_READS(MAX_READS)
	) dut_i (
		.CLK_400M(CLK_400M),
		.reset_n(reset_n),
		.core_start(core_start),
		.spl_tx_rd_almostfull(spl_tx_rd_almostfull),
		.cor_tx_rd_valid(cor_tx_rd_valid),
		.cor_tx_rd_addr(cor_tx_rd_addr),
		.io_rx_rd_valid(io_rx_rd_valid),
		.io_rx_data(io_rx_data),
		.spl_tx_wr_almostfull(spl_tx_wr_almostfull),
		.cor_tx_wr_valid(cor_tx_wr_valid),
		.cor_tx_fence_valid(cor_tx_fence_valid),
		.cor_tx_done_valid(cor_tx_done_valid),
		.cor_tx_wr_addr(cor_tx_wr_addr),
		.cor_tx_data(cor_tx_data),
		.io_src_ptr(io_src_ptr),
		.io_dst_ptr(io_dst_ptr)
	);

	// ==============================
	// Reference model
	// ==============================
	function automatic afu_pkg::addr_t hand_addr();
		return afu_pkg::addr_t'(SRC_PTR + HS_OFS);
	endfunction

	function automatic afu_pkg::addr_t input_addr(afu_pkg::cl_count_t idx);
		return afu_pkg::addr_t'(SRC_PTR + HS_OFS + 64'd1) + afu_pkg::addr_t'(idx);
	endfunction

	// Every 64-bit word carries the full line address, its slot and the batch salt
	function automatic afu_pkg::cl_t fill_line(afu_pkg::addr_t a, logic [31:0] s);
		afu_pkg::cl_t l;
		for (int k = 0; k < 8; k++) begin
			l[k*64 +: 64] = {a ^ {26'd0, s}, 6'(k)};
		end
		return l;
	endfunction

	function automatic afu_pkg::cl_t host_line(afu_pkg::addr_t a);
		if (a == hand_addr()) begin
			return hs_line;
		end
		return fill_line(a, salt);
	endfunction

	function automatic afu_pkg::cl_t expected_line(afu_pkg::cl_count_t idx);
		return fill_line(input_addr(idx), salt);
	endfunction

	// ==============================
	// Compare and failure tasks
	// ==============================
	task automatic fail_run(string what);
		$display("ERROR: %s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic check_cl(string name, afu_pkg::cl_t exp, afu_pkg::cl_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "line mismatch in %s", name);
		end
	endtask

	task automatic check_addr(string name, afu_pkg::addr_t exp, afu_pkg::addr_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "address mismatch in %s", name);
		end
	endtask

	task automatic check_count(string name, afu_pkg::cl_count_t exp, afu_pkg::cl_count_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "count mismatch in %s", name);
		end
	endtask

	// ==============================
	// Host memory model
	// ==============================
	// Requests captured at the rising edge, answered in order on falling edges
	always @(negedge CLK_400M) begin
		int lat;
		int due;
		while (new_reqs.size() > 0) begin
			lat = 1 + int'($urandom % 8);
			due = cycle + lat;
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			pend_addr.push_back(new_reqs.pop_front());
			pend_due.push_back(due);
		end
		if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
			io_rx_rd_valid = 1'b1;
			io_rx_data = host_line(pend_addr.pop_front());
			void'(pend_due.pop_front());
		end else begin
			io_rx_rd_valid = 1'b0;
			io_rx_data = '0;
		end
		spl_tx_rd_almostfull = ($urandom % 4) == 0;
		spl_tx_wr_almostfull = ($urandom % 4) == 0;
		cycle++;
	end

	// ==============================
	// Checker
	// ==============================
	always @(posedge CLK_400M) begin
		if (!started && (cor_tx_rd_valid || cor_tx_wr_valid || cor_tx_fence_valid ||
		                 cor_tx_done_valid)) begin
			fail_run("valid output asserted before core_start");
		end
		if (cor_tx_rd_valid) begin
			if (spl_tx_rd_almostfull) begin
				fail_run("read request issued while read almost-full was high");
			end
			new_reqs.push_back(cor_tx_rd_addr);
			if (cor_tx_rd_addr == hand_addr()) begin
				if (load_cnt != 0) begin
					fail_run("handshake read in the middle of a batch");
				end
				poll_cnt++;
			end else begin
				if (!armed) begin
					fail_run("load read issued while the expected tag was clear");
				end
				if (load_cnt >= cur_lines) begin
					fail_run("more load reads than the batch holds");
				end
				check_addr("load read address", input_addr(load_cnt), cor_tx_rd_addr);
				load_cnt++;
			end
		end
		if (cor_tx_wr_valid) begin
			if (spl_tx_wr_almostfull) begin
				fail_run("write issued while write almost-full was high");
			end
			if (!armed) begin
				fail_run("write issued with no batch in progress");
			end
			if (wr_step < int'(cur_lines)) begin
				if (cor_tx_fence_valid || cor_tx_done_valid) begin
					fail_run("fence or done write before all lines were written");
				end
				check_addr("destination address",
				           afu_pkg::addr_t'(DST_PTR) + afu_pkg::addr_t'(wr_step),
				           cor_tx_wr_addr);
				check_cl("destination data", expected_line(afu_pkg::cl_count_t'(wr_step)),
				         cor_tx_data);
			end else if (wr_step == int'(cur_lines)) begin
				if (!cor_tx_fence_valid || cor_tx_done_valid) begin
					fail_run("first fence missing after the last line");
				end
				check_count("load reads in batch", cur_lines, load_cnt);
			end else if (wr_step == int'(cur_lines) + 1) begin
				if (!cor_tx_done_valid || cor_tx_fence_valid) begin
					fail_run("done write missing after the first fence");
				end
				check_addr("done write address", hand_addr(), cor_tx_wr_addr);
				check_cl("done word", {32'd16, 480'd0}, cor_tx_data);
				hs_line = cor_tx_data;
			end else begin
				if (!cor_tx_fence_valid || cor_tx_done_valid) begin
					fail_run("second fence missing after the done write");
				end
			end
			wr_step++;
			// Second fence closes the batch
			if (wr_step == int'(cur_lines) + 3) begin
				wr_step = 0;
				load_cnt = '0;
				armed = 1'b0;
				batches_done++;
			end
		end else if (cor_tx_fence_valid || cor_tx_done_valid) begin
			fail_run("fence or done valid without write valid");
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	task automatic set_handshake(afu_pkg::batch_size_t size, int tag_bit);
		hs_line = '0;
		hs_line[448 +: 9] = size;
		hs_line[tag_bit] = 1'b1;
	endtask

	task automatic arm_batch(afu_pkg::batch_size_t size, int tag_bit, logic [31:0] s);
		salt = s;
		cur_lines = afu_pkg::cl_count_t'(size * 4);
		armed = 1'b1;
		set_handshake(size, tag_bit);
	endtask

	task automatic wait_polls(int n);
		int target;
		int waited;
		target = poll_cnt + n;
		waited = 0;
		while (poll_cnt < target) begin
			@(negedge CLK_400M);
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_run("timed out waiting for handshake polls");
			end
		end
	endtask

	task automatic wait_batches(int n);
		int waited;
		waited = 0;
		while (batches_done < n) begin
			@(negedge CLK_400M);
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_run("timed out waiting for a batch to finish");
			end
		end
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (reset_n !== 1'b1) begin
			@(negedge CLK_400M);
			waited++;
			if (waited > 100) begin
				fail_run("reset was never released");
			end
		end
	endtask

	initial begin
		core_start = 1'b0;
		spl_tx_rd_almostfull = 1'b0;
		spl_tx_wr_almostfull = 1'b0;
		io_rx_rd_valid = 1'b0;
		io_rx_data = '0;
		io_src_ptr = SRC_PTR;
		io_dst_ptr = DST_PTR;
		hs_line = '0;
		salt = '0;
		cur_lines = '0;
		load_cnt = '0;
		wr_step = 0;
		poll_cnt = 0;
		batches_done = 0;
		armed = 1'b0;
		started = 1'b0;
		cycle = 0;
		last_due = 0;
		void'($urandom(32'h0456_a577));

		wait_reset_release();
		repeat (8) @(negedge CLK_400M);
		started = 1'b1;
		core_start = 1'b1;

		// Tag clear at first, then a batch of five reads on tag 0
		wait_polls(3);
		arm_batch(9'd5, 480, 32'h0001_3c5a);
		wait_batches(1);

		// Stale tag 0 is ignored once the expected tag has toggled
		set_handshake(9'd2, 480);
		wait_polls(4);
		arm_batch(9'd2, 482, 32'h0002_9e17);
		wait_batches(2);

		// Empty batch back on tag 0
		arm_batch(9'd0, 480, 32'h0003_47d1);
		wait_batches(3);
		wait_polls(2);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/afu_pkg.sv
hdl/batch_fetch.sv
hdl/read_buffer.sv
hdl/result_writer.sv
hdl/afu_core.sv
tb/clk_gen.sv
tb/afu_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the batch engine testbench with Verilator and runs it.
# A failing run ends in $fatal, so the exit status reports the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module afu_core_tb \
	-f sources.f \
	-o afu_core_tb_sim

./obj_dir/afu_core_tb_sim
